// ==== eth_frame_fifo.f ====
+incdir+tests
rtl/eth_fifo_pkg.sv
rtl/frame_fifo.sv
rtl/egress_pacer.sv
rtl/fifo_csr.sv
rtl/eth_frame_fifo.sv
tests/tb_eth_frame_fifo.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the frame FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f eth_frame_fifo.f --top-module tb_eth_frame_fifo
./obj_dir/Vtb_eth_frame_fifo > sim.log 2>&1
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi

// ==== tests/tb_tasks.svh ====
//############################################################################
// Testbench tasks
// APB read and write, frame send and drain wait
// Error reporting and per-test result lines
//############################################################################

function automatic logic is_mapped(input logic [7:0] addr);
    return addr inside {CTRL, IFG, GOOD_CNT, BAD_CNT, OVF_CNT};
endfunction

function automatic int rand_len();
    logic [31:0] r;
    r = $random(seed);
    return int'(r[2:0]) + 1;
endfunction

task automatic report_value(input string name, input logic [73:0] expected,
                            input logic [73:0] actual);
    $display("Error: time %0t, %s expected %0h, got %0h", $time, name, expected, actual);
    errors++;
endtask

task automatic report_fail(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    errors++;
endtask

// Both APB tasks start and end on a falling edge
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    err_exp = !is_mapped(addr);
    @(negedge logic_clk);
    penable = 1'b1;
    @(negedge logic_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (addr == CTRL) ctrl_exp = data[0];
    if (addr == IFG) ifg_exp = data[7:0];
endtask

task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected);
    paddr    = addr;
    pwrite   = 1'b0;
    psel     = 1'b1;
    err_exp  = !is_mapped(addr);
    rd_exp   = expected;
    rd_check = 1'b1;
    @(negedge logic_clk);
    penable = 1'b1;
    @(negedge logic_clk);
    psel     = 1'b0;
    penable  = 1'b0;
    rd_check = 1'b0;
endtask

// Surviving frames go to the scoreboard before they are sent
task automatic send_frame(input int len, input logic bad, input logic keep_frame);
    axis_beat_t  beat;
    logic [31:0] rnd;
    for (int b = 0; b < len; b++) begin
        rnd        = $random(seed);
        beat.data  = {$random(seed), $random(seed)};
        beat.last  = (b == len - 1);
        beat.keep  = beat.last ? (8'hFF >> rnd[2:0]) : 8'hFF;
        beat.bad   = beat.last && bad;
        if (keep_frame) exp_q.push_back(beat);
        in_beat  = beat;
        in_valid = 1'b1;
        if (!in_ready) saw_stall = 1'b1;
        while (!in_ready) @(negedge logic_clk);
        @(negedge logic_clk);
    end
    in_valid = 1'b0;
    if (bad) bad_exp++;
    else if (keep_frame) good_exp++;
    else ovf_exp++;
endtask

task automatic wait_drain();
    while (exp_count != 0) @(negedge logic_clk);
    repeat (int'(ifg_exp) + 2) @(negedge logic_clk);
endtask

task automatic finish_test(input string name);
    test_num++;
    if (errors == errors_at_start) begin
        tests_ok++;
        $display("test %0d %s: ok", test_num, name);
    end else begin
        tests_bad++;
        $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
    end
    errors_at_start = errors;
endtask

// ==== tests/tb_eth_frame_fifo.sv ====
//############################################################################
// Testbench for the Ethernet frame FIFO
// Clock, reset, DUT, scoreboard queue and concurrent checks
// Test sequence, watchdog and result lines
//############################################################################

`timescale 1ns/1ns

module tb_eth_frame_fifo import eth_fifo_pkg::*; ();

    localparam int DEPTH       = 16;
    localparam int CLK_PERIOD  = 20;
    // Watchdog budget, every beat followed by the longest gap
    localparam int TOTAL_BEATS = 340;
    localparam int MAX_GAP     = 13;
    localparam int MARGIN      = 4;

    logic        logic_clk = 1'b0;
    logic        logic_rst;
    axis_beat_t  in_beat;
    axis_beat_t  out_beat;
    logic        in_valid, in_ready, out_valid, out_ready;
    logic [7:0]  paddr;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [31:0] pwdata, prdata;

    integer      seed = 32'h3c43;
    logic [31:0] stall_rnd;

    // Scoreboard and register model
    axis_beat_t  exp_q [$];
    axis_beat_t  exp_head;
    int          exp_count = 0;
    logic [31:0] rd_exp = '0;
    logic        rd_check = 1'b0;
    logic        err_exp = 1'b0;
    logic        ctrl_exp = 1'b0;
    logic [7:0]  ifg_exp = 8'd12;
    int          good_exp = 0, bad_exp = 0, ovf_exp = 0;

    logic        rand_stall = 1'b0, hold_out = 1'b0, saw_stall = 1'b0;
    logic        gap_armed;
    int          idle_cycles;
    int          errors = 0, errors_at_start = 0;
    int          test_num = 0, tests_ok = 0, tests_bad = 0;

    eth_frame_fifo #(.DEPTH (DEPTH)) u_eth_frame_fifo (.*);

    `include "tb_tasks.svh"

    always #(CLK_PERIOD / 2) logic_clk = ~logic_clk;

    // Output back-pressure
    always @(negedge logic_clk) begin
        stall_rnd = $random(seed);
        if (hold_out) out_ready = 1'b0;
        else if (rand_stall) out_ready = (stall_rnd[1:0] != 2'b00);
        else out_ready = 1'b1;
    end

    always @(posedge logic_clk) begin
        if (!logic_rst && out_valid && out_ready && exp_q.size() > 0) exp_q.delete(0);
        exp_count <= exp_q.size();
        exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // Idle cycles since the last end of frame
    always @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            gap_armed   <= 1'b0;
            idle_cycles <= 0;
        end else if (out_valid && out_ready && out_beat.last) begin
            gap_armed   <= 1'b1;
            idle_cycles <= 0;
        end else if (out_valid) begin
            gap_armed <= 1'b0;
        end else begin
            idle_cycles <= idle_cycles + 1;
        end
    end

    a_out_expected: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (out_valid && out_ready) |-> (exp_count > 0))
        else report_fail("beat left the FIFO with no frame expected");
    a_out_beat: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (out_valid && out_ready && exp_count > 0) |-> (out_beat == exp_head))
        else report_value("out_beat", $sampled(exp_head), $sampled(out_beat));
    a_prdata: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (psel && penable && !pwrite && rd_check && !err_exp) |-> (prdata == rd_exp))
        else report_value("prdata", $sampled(rd_exp), $sampled(prdata));
    a_pslverr: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (psel && penable) |-> (pslverr == err_exp && pready))
        else report_value("pslverr", $sampled(err_exp), $sampled(pslverr));
    a_no_stall_drop: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (in_valid && !in_ready) |-> !ctrl_exp)
        else report_fail("in_ready went low with drop_when_full set");
    a_gap: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (out_valid && gap_armed) |-> (idle_cycles >= int'(ifg_exp)))
        else report_value("idle cycles", $sampled(ifg_exp), $sampled(idle_cycles));

    initial begin
        int n;
        logic_rst = 1'b1;
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        repeat (5) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;

        apb_read(CTRL, 32'd0);
        apb_read(IFG, 32'd12);
        apb_read(GOOD_CNT, 32'd0);
        apb_read(BAD_CNT, 32'd0);
        apb_read(OVF_CNT, 32'd0);
        apb_write(CTRL, 32'd1);
        apb_read(CTRL, 32'd1);
        apb_write(IFG, 32'h5a);
        apb_read(IFG, 32'h5a);
        apb_write(IFG, 32'd12);
        apb_write(CTRL, 32'd0);
        apb_read(8'h14, 32'd0);
        apb_write(8'h40, 32'hffff);
        finish_test("register reset and access");

        rand_stall = 1'b1;
        for (n = 0; n < 20; n++) send_frame(rand_len(), 1'b0, 1'b1);
        wait_drain();
        rand_stall = 1'b0;
        apb_read(GOOD_CNT, good_exp);
        finish_test("good frames");

        // Every third frame marked bad
        for (n = 0; n < 12; n++) send_frame(rand_len(), n % 3 == 1, n % 3 != 1);
        wait_drain();
        apb_read(BAD_CNT, bad_exp);
        apb_read(GOOD_CNT, good_exp);
        finish_test("bad frames");

        // Second frame finds only 6 free beats and is dropped
        apb_write(CTRL, 32'd1);
        hold_out = 1'b1;
        send_frame(10, 1'b0, 1'b1);
        send_frame(8, 1'b0, 1'b0);
        repeat (2) @(negedge logic_clk);
        apb_read(OVF_CNT, ovf_exp);
        hold_out = 1'b0;
        wait_drain();
        // Same pair without dropping, input waits for the reader
        apb_write(CTRL, 32'd0);
        hold_out  = 1'b1;
        saw_stall = 1'b0;
        fork
            begin
                send_frame(10, 1'b0, 1'b1);
                send_frame(8, 1'b0, 1'b1);
            end
            begin
                // Release the reader after the stall, or after a bounded wait
                for (int c = 0; c < 4 * DEPTH && !saw_stall; c++) begin
                    @(negedge logic_clk);
                end
                repeat (8) @(negedge logic_clk);
                hold_out = 1'b0;
            end
        join
        wait_drain();
        a_input_stalled: assert (saw_stall)
            else report_fail("in_ready never fell while the memory was full");
        send_frame(DEPTH + 4, 1'b0, 1'b0);
        wait_drain();
        apb_read(OVF_CNT, ovf_exp);
        apb_read(GOOD_CNT, good_exp);
        finish_test("overflow");

        apb_write(IFG, 32'd5);
        for (n = 0; n < 4; n++) send_frame(3, 1'b0, 1'b1);
        wait_drain();
        apb_read(GOOD_CNT, good_exp);
        apb_write(GOOD_CNT, 32'd0);
        apb_write(BAD_CNT, 32'd1);
        apb_write(OVF_CNT, 32'hffff);
        apb_read(GOOD_CNT, 32'd0);
        apb_read(BAD_CNT, 32'd0);
        apb_read(OVF_CNT, 32'd0);
        finish_test("gap and counter clear");

        $display("Summary: %0d tests, %0d clean, %0d with errors, %0d failed checks",
                 test_num, tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_BEATS * MAX_GAP * MARGIN * CLK_PERIOD);
        $display("Timeout: run did not finish within the watchdog budget");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== rtl/eth_frame_fifo.sv ====
//############################################################################
// Ethernet frame FIFO top level
// Frame FIFO, egress pacer and APB status/configuration block
//############################################################################

`timescale 1ns/1ns

module eth_frame_fifo import eth_fifo_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic        logic_clk,
    input  logic        logic_rst,

    // Frame input
    input  axis_beat_t  in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    // Paced frame output
    output axis_beat_t  out_beat,
    output logic        out_valid,
    input  logic        out_ready,

    // APB
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    axis_beat_t  fifo_beat;
    logic        fifo_valid;
    logic        fifo_ready;
    fifo_cfg_t   cfg;
    fifo_event_t events;

    frame_fifo #(
        .DEPTH (DEPTH)
    ) u_frame_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .cfg        (cfg),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .events     (events)
    );

    egress_pacer u_egress_pacer (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .cfg        (cfg),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    fifo_csr u_fifo_csr (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .events    (events),
        .cfg       (cfg)
    );

endmodule

// ==== rtl/fifo_csr.sv ====
//############################################################################
// APB register block
// CTRL and IFG configuration registers
// Good, bad and overflow frame counters, cleared by any write
//############################################################################

`timescale 1ns/1ns

module fifo_csr import eth_fifo_pkg::*; (
    input  logic        logic_clk,
    input  logic        logic_rst,

    // APB slave, no wait states
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    input  fifo_event_t events,
    output fifo_cfg_t   cfg
);

    localparam logic [7:0] IFG_RESET = 8'd12;

    logic             access;
    logic             wr_en;
    logic             addr_hit;
    logic [2:0]       ev_vec;
    logic [2:0]       clr_vec;
    logic [CNT_W-1:0] cnt [3];

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;

    // Counter order: good, bad, overflow
    assign ev_vec  = {events.overflow, events.bad, events.good};
    assign clr_vec = {
        wr_en && (paddr == OVF_CNT),
        wr_en && (paddr == BAD_CNT),
        wr_en && (paddr == GOOD_CNT)
    };

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            cfg.drop_when_full <= 1'b0;
            cfg.ifg_delay      <= IFG_RESET;
        end else if (wr_en) begin
            if (paddr == CTRL) begin
                cfg.drop_when_full <= pwdata[0];
            end
            if (paddr == IFG) begin
                cfg.ifg_delay <= pwdata[7:0];
            end
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                // Clear wins over a same-cycle event
                if (clr_vec[i]) begin
                    cnt[i] <= '0;
                end else if (ev_vec[i]) begin
                    cnt[i] <= cnt[i] + CNT_W'(1);
                end
            end
        end
    end

    // Read mux and address check
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (csr_addr_e'(paddr))
            CTRL:     prdata = {31'd0, cfg.drop_when_full};
            IFG:      prdata = {24'd0, cfg.ifg_delay};
            GOOD_CNT: prdata = {{(32-CNT_W){1'b0}}, cnt[0]};
            BAD_CNT:  prdata = {{(32-CNT_W){1'b0}}, cnt[1]};
            OVF_CNT:  prdata = {{(32-CNT_W){1'b0}}, cnt[2]};
            default:  addr_hit = 1'b0;
        endcase
    end

    assign pslverr = access && !addr_hit;

    // Bus master must hold psel through the access phase
    a_apb_penable: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        penable |-> psel
    ) else $error("fifo_csr: penable without psel");

endmodule

// ==== rtl/egress_pacer.sv ====
//############################################################################
// Egress pacer
// Holds the output idle for ifg_delay cycles after each frame
//############################################################################

`timescale 1ns/1ns

module egress_pacer import eth_fifo_pkg::*; (
    input  logic       logic_clk,
    input  logic       logic_rst,

    input  fifo_cfg_t  cfg,

    input  axis_beat_t fifo_beat,
    input  logic       fifo_valid,
    output logic       fifo_ready,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    pacer_state_e state;
    logic [7:0]   gap_cnt;
    logic         last_xfer;

    // Beats pass straight through while not in the gap
    assign out_beat   = fifo_beat;
    assign out_valid  = (state == PASS) && fifo_valid;
    assign fifo_ready = (state == PASS) && out_ready;

    assign last_xfer = out_valid && out_ready && out_beat.last;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state   <= PASS;
            gap_cnt <= '0;
        end else begin
            case (state)
                PASS: begin
                    if (last_xfer && cfg.ifg_delay != 8'd0) begin
                        state   <= GAP;
                        gap_cnt <= cfg.ifg_delay;
                    end
                end
                GAP: begin
                    // One idle cycle per count
                    gap_cnt <= gap_cnt - 8'd1;
                    if (gap_cnt <= 8'd1) begin
                        state <= PASS;
                    end
                end
                default: state <= PASS;
            endcase
        end
    end

    // End of frame with a nonzero gap leaves the output idle next cycle
    a_gap_idle: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (last_xfer && cfg.ifg_delay != 8'd0) |=> (state == GAP) && !out_valid
    ) else $error("egress_pacer: output active inside the gap");

endmodule

// ==== rtl/frame_fifo.sv ====
//############################################################################
// Store-and-forward frame FIFO
// Commits good frames on their last beat, rewinds bad and overflowed ones
// Raises good, bad and overflow event pulses
//############################################################################

`timescale 1ns/1ns

module frame_fifo import eth_fifo_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic        logic_clk,
    input  logic        logic_rst,

    input  fifo_cfg_t   cfg,

    // Write side
    input  axis_beat_t  in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    // Read side, committed frames only
    output axis_beat_t  fifo_beat,
    output logic        fifo_valid,
    input  logic        fifo_ready,

    output fifo_event_t events
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    axis_beat_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] commit_ptr;
    logic [PTR_W-1:0] rd_ptr;

    logic [PTR_W-1:0] used;
    logic [PTR_W-1:0] frame_len;
    logic             full;
    logic             frame_full;
    logic             drop_frame;
    logic             beat_acc;
    logic             store;

    assign used       = wr_ptr - rd_ptr;
    assign frame_len  = wr_ptr - commit_ptr;
    assign full       = (used == PTR_W'(DEPTH));

    // Current frame alone fills the memory, so it can never commit
    assign frame_full = (frame_len == PTR_W'(DEPTH));

    // Stall only when waiting for the read side can help
    assign in_ready = !full || cfg.drop_when_full || drop_frame || frame_full;

    assign beat_acc = in_valid && in_ready;
    assign store    = beat_acc && !drop_frame && !full;

    always_ff @(posedge logic_clk) begin
        if (store) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            drop_frame <= 1'b0;
            events     <= '0;
        end else begin
            events <= '0;

            if (fifo_valid && fifo_ready) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end

            if (beat_acc) begin
                if (drop_frame || full) begin
                    // Overflow, discard through the last beat
                    wr_ptr          <= commit_ptr;
                    drop_frame      <= !in_beat.last;
                    events.overflow <= in_beat.last;
                end else if (in_beat.last) begin
                    if (in_beat.bad) begin
                        wr_ptr     <= commit_ptr;
                        events.bad <= 1'b1;
                    end else begin
                        wr_ptr      <= wr_ptr + PTR_W'(1);
                        commit_ptr  <= wr_ptr + PTR_W'(1);
                        events.good <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + PTR_W'(1);
                end
            end
        end
    end

    // Reads never pass the commit point
    assign fifo_valid = (rd_ptr != commit_ptr);
    assign fifo_beat  = mem[rd_ptr[ADDR_W-1:0]];

    // Occupancy bounded by DEPTH, including the frame being written
    a_fill_bound: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (used <= PTR_W'(DEPTH)) && ((commit_ptr - rd_ptr) <= used)
    ) else $error("frame_fifo: occupancy out of range");

    // At most one status pulse per accepted last beat
    a_event_onehot: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        $onehot0(events)
    ) else $error("frame_fifo: event pulses not one-hot");

endmodule

// ==== rtl/eth_fifo_pkg.sv ====
//############################################################################
// Shared definitions for the Ethernet frame FIFO
// Stream beat, frame event and configuration structs
// CSR word addresses and pacer state encoding
//############################################################################

package eth_fifo_pkg;

    // Beat and counter widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;
    localparam int CNT_W  = 16;

    // One stream beat, bad is only looked at on the last beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              bad;
    } axis_beat_t;

    // Single-cycle frame status pulses
    typedef struct packed {
        logic good;
        logic bad;
        logic overflow;
    } fifo_event_t;

    // Runtime configuration from the register block
    typedef struct packed {
        logic       drop_when_full;
        logic [7:0] ifg_delay;
    } fifo_cfg_t;

    // APB register map, byte addresses of 32-bit words
    typedef enum logic [7:0] {
        CTRL     = 8'h00,
        IFG      = 8'h04,
        GOOD_CNT = 8'h08,
        BAD_CNT  = 8'h0C,
        OVF_CNT  = 8'h10
    } csr_addr_e;

    typedef enum logic {
        PASS = 1'b0,
        GAP  = 1'b1
    } pacer_state_e;

endpackage
